// ==== list.f ====
common/snake_pkg.sv
hdl/step_timer.sv
snake/snake_body.sv
display/digit_scan.sv
hdl/snake_top.sv
test/snake_props.sv
test/tb_snake.sv

// ==== Bender.yml ====
package:
  name: snake

sources:
  - common/snake_pkg.sv
  - hdl/step_timer.sv
  - snake/snake_body.sv
  - display/digit_scan.sv
  - hdl/snake_top.sv
  - target: test
    files:
      - test/snake_props.sv
      - test/tb_snake.sv

// ==== test/tb_snake.sv ====
`timescale 1ns/1ps

module tb_snake;

    import snake_pkg::*;

    localparam int CLK_PERIOD     = 4;
    localparam int DRIVE_DELAY    = 1;
    localparam int RESET_CYCLES   = 2;
    localparam int TOTAL_RUN      = 3 * PATH_LEN * STEP_CYCLES;
    localparam int TAIL_CYCLES    = 2 * NUM_DIGITS;
    localparam int MAX_PAUSES     = 12;
    localparam int MAX_PAUSE_LEN  = 24;
    localparam int PLANNED_CYCLES = RESET_CYCLES + TOTAL_RUN + TAIL_CYCLES
                                    + MAX_PAUSES * MAX_PAUSE_LEN;
    localparam logic [31:0] SEED  = 32'h7fe34657;

    logic       clock_250hz = 1'b0;
    logic       rst_n;
    logic       run;
    logic [7:0] digit_sel;
    logic [7:0] segments;

    logic [31:0] lcg_state;
    int          pause_count;

    // model state
    int         m_count;
    int         m_pos [SNAKE_LEN];
    int         m_idx;
    logic [7:0] m_seg;
    int         m_laps;
    int         active_edges;
    bit         model_ready = 1'b0;

    snake_top u_snake_top (
        .clock_250hz (clock_250hz),
        .rst_n       (rst_n),
        .run         (run),
        .digit_sel   (digit_sel),
        .segments    (segments)
    );

    always #(CLK_PERIOD / 2) clock_250hz = ~clock_250hz;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // segment that path position p lights on the given digit
    function automatic logic [7:0] frame_mask(input int digit, input int p);
        logic [7:0] mask;
        mask = 8'h00;
        if (p < 8) begin
            if (digit == p) mask[SEG_A] = 1'b1;
        end else if (p == 8) begin
            if (digit == 7) mask[SEG_B] = 1'b1;
        end else if (p == 9) begin
            if (digit == 7) mask[SEG_C] = 1'b1;
        end else if (p < 18) begin
            // bottom row runs right to left
            if (digit == 17 - p) mask[SEG_D] = 1'b1;
        end else if (p == 18) begin
            if (digit == 0) mask[SEG_E] = 1'b1;
        end else if (p == 19) begin
            if (digit == 0) mask[SEG_F] = 1'b1;
        end
        return mask;
    endfunction

    function automatic logic [7:0] expected_segments(input int digit, input int p0,
                                                     input int p1, input int p2,
                                                     input int p3);
        return frame_mask(digit, p0) | frame_mask(digit, p1)
             | frame_mask(digit, p2) | frame_mask(digit, p3);
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    // cycle model, run and rst_n are stable at the edge
    always @(posedge clock_250hz) begin
        bit step;
        int next_idx;
        if (!rst_n) begin
            m_count      = 0;
            m_idx        = 0;
            m_seg        = 8'h00;
            m_laps       = 0;
            active_edges = 0;
            for (int i = 0; i < SNAKE_LEN; i++) begin
                m_pos[i] = SNAKE_LEN - 1 - i;
            end
        end else begin
            step     = run && (m_count == STEP_CYCLES - 1);
            next_idx = (m_idx + 1) % NUM_DIGITS;
            // pattern uses positions from before this edge
            m_seg    = expected_segments(next_idx, m_pos[0], m_pos[1], m_pos[2], m_pos[3]);
            m_idx    = next_idx;
            if (step) begin
                for (int i = SNAKE_LEN - 1; i > 0; i--) begin
                    m_pos[i] = m_pos[i-1];
                end
                m_pos[0] = (m_pos[0] + 1) % PATH_LEN;
                if (m_pos[0] == 0) m_laps++;
            end
            if (run) begin
                m_count = (m_count == STEP_CYCLES - 1) ? 0 : m_count + 1;
            end
            active_edges++;
        end
        model_ready = 1'b1;
    end

    // outputs are settled half a cycle after the edge
    always @(negedge clock_250hz) begin
        logic [7:0] exp_sel;
        if (model_ready) begin
            exp_sel = 8'h01 << m_idx;
            assert (digit_sel == exp_sel) else
                report_failure($sformatf("MISMATCH at %0t: digit_sel expected %b observed %b",
                                         $time, exp_sel, digit_sel));
            assert (segments == m_seg) else
                report_failure($sformatf(
                    "MISMATCH at %0t: segments of digit %0d expected %b observed %b",
                    $time, m_idx, m_seg, segments));
            assert (u_snake_top.u_digit_scan.u_snake_props.fail_count == 0) else
                report_failure("a scanner property failed during the run");
            // first return to digit 0, only the tail on its top bar
            if (active_edges == NUM_DIGITS) begin
                assert (segments == 8'b0000_0001) else
                    report_failure($sformatf("MISMATCH at %0t: first digit 0 pattern observed %b",
                                             $time, segments));
            end
        end
    end

    initial begin : stimulus
        int          run_cycles;
        int          pause_left;
        logic [31:0] rnd;
        run_cycles  = 0;
        pause_left  = 0;
        pause_count = 0;
        lcg_state   = SEED;
        rst_n       = 1'b0;
        run         = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock_250hz);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
        while (run_cycles < TOTAL_RUN) begin
            if (pause_left > 0) begin
                pause_left--;
                run = 1'b0;
            end else begin
                rnd = next_rand();
                if (pause_count < MAX_PAUSES && rnd[31:24] < 8'd5) begin
                    pause_left = rnd[23:16] % MAX_PAUSE_LEN;
                    pause_count++;
                    run = 1'b0;
                end else begin
                    run = 1'b1;
                    run_cycles++;
                end
            end
            @(posedge clock_250hz);
            #(DRIVE_DELAY);
        end
        run = 1'b1;
        repeat (TAIL_CYCLES) begin
            @(posedge clock_250hz);
            #(DRIVE_DELAY);
        end
        assert (m_laps >= 3) else
            report_failure("the snake went round the frame fewer than three times");
        assert (pause_count > 0) else
            report_failure("no pause window was driven during the run");
        if (u_snake_top.u_digit_scan.u_snake_props.fail_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            report_failure("a scanner property failed during the run");
        end
    end

    initial begin : watchdog
        #(2 * PLANNED_CYCLES * CLK_PERIOD);
        report_failure("timeout, the test did not reach its end in time");
    end

endmodule

// ==== test/snake_props.sv ====
`timescale 1ns/1ps

module snake_props (
    input logic       clock_250hz,
    input logic       rst_n,
    input logic [7:0] digit_sel,
    input logic [7:0] segments
);

    import snake_pkg::*;

    int unsigned fail_count = 0;

    a_sel_one_hot: assert property (@(posedge clock_250hz) disable iff (!rst_n)
        $onehot(digit_sel))
        else begin
            $error("digit select is not one-hot");
            fail_count++;
        end

    // one place left per cycle, bit 7 back to bit 0
    a_sel_rotates: assert property (@(posedge clock_250hz) disable iff (!rst_n)
        $past(rst_n) |-> digit_sel == {$past(digit_sel[6:0]), $past(digit_sel[7])})
        else begin
            $error("digit select did not rotate by one place");
            fail_count++;
        end

    a_no_g_dp: assert property (@(posedge clock_250hz) disable iff (!rst_n)
        !segments[SEG_G] && !segments[SEG_DP])
        else begin
            $error("middle bar or decimal point lit");
            fail_count++;
        end

endmodule

bind digit_scan snake_props u_snake_props (
    .clock_250hz (clock_250hz),
    .rst_n       (rst_n),
    .digit_sel   (digit_sel),
    .segments    (segments)
);

// ==== hdl/snake_top.sv ====
`timescale 1ns/1ps

module snake_top (
    input  logic       clock_250hz,
    input  logic       rst_n,
    input  logic       run,
    output logic [7:0] digit_sel,
    output logic [7:0] segments
);

    import snake_pkg::*;

    logic             step;
    logic [POS_W-1:0] pos0;
    logic [POS_W-1:0] pos1;
    logic [POS_W-1:0] pos2;
    logic [POS_W-1:0] pos3;

    // step enable, paused by run
    step_timer u_step_timer (
        .clock_250hz (clock_250hz),
        .rst_n       (rst_n),
        .run         (run),
        .step        (step)
    );

    // head and trailing positions on the path
    snake_body u_snake_body (
        .clock_250hz (clock_250hz),
        .rst_n       (rst_n),
        .step        (step),
        .pos0        (pos0),
        .pos1        (pos1),
        .pos2        (pos2),
        .pos3        (pos3)
    );

    // multiplexed display drive
    digit_scan u_digit_scan (
        .clock_250hz (clock_250hz),
        .rst_n       (rst_n),
        .pos0        (pos0),
        .pos1        (pos1),
        .pos2        (pos2),
        .pos3        (pos3),
        .digit_sel   (digit_sel),
        .segments    (segments)
    );

endmodule

// ==== display/digit_scan.sv ====
`timescale 1ns/1ps

module digit_scan (
    input  logic                       clock_250hz,
    input  logic                       rst_n,
    input  logic [snake_pkg::POS_W-1:0] pos0,
    input  logic [snake_pkg::POS_W-1:0] pos1,
    input  logic [snake_pkg::POS_W-1:0] pos2,
    input  logic [snake_pkg::POS_W-1:0] pos3,
    output logic [7:0]                 digit_sel,
    output logic [7:0]                 segments
);

    import snake_pkg::*;

    logic [NUM_DIGITS-1:0] next_sel;
    logic [DIGIT_W-1:0]    next_idx;
    logic [POS_W-1:0]      body [SNAKE_LEN];
    logic [NUM_SEGS-1:0]   next_pattern;

    // gather the loose position ports, head first
    assign body[0] = pos0;
    assign body[1] = pos1;
    assign body[2] = pos2;
    assign body[3] = pos3;

    // rotate left, bit 7 wraps to bit 0
    assign next_sel = {digit_sel[NUM_DIGITS-2:0], digit_sel[NUM_DIGITS-1]};

    // index of the digit selected after this edge
    always_comb begin
        next_idx = '0;
        for (int d = 0; d < NUM_DIGITS; d++) begin
            if (next_sel[d]) begin
                next_idx = DIGIT_W'(d);
            end
        end
    end

    // OR the masks of every body segment that sits on that digit
    always_comb begin
        next_pattern = '0;
        for (int i = 0; i < SNAKE_LEN; i++) begin
            if (path_digit(body[i]) == next_idx) begin
                next_pattern = next_pattern | path_seg(body[i]);
            end
        end
    end

    // scan keeps running whether or not the snake moves
    always_ff @(posedge clock_250hz or negedge rst_n) begin
        if (!rst_n) begin
            digit_sel <= 8'b0000_0001;
        end else begin
            digit_sel <= next_sel;
        end
    end

    // pattern lines up with the digit select it is loaded with
    always_ff @(posedge clock_250hz or negedge rst_n) begin
        if (!rst_n) begin
            segments <= '0;
        end else begin
            segments <= next_pattern;
        end
    end

endmodule

// ==== snake/snake_body.sv ====
`timescale 1ns/1ps

module snake_body (
    input  logic                       clock_250hz,
    input  logic                       rst_n,
    input  logic                       step,
    output logic [snake_pkg::POS_W-1:0] pos0,
    output logic [snake_pkg::POS_W-1:0] pos1,
    output logic [snake_pkg::POS_W-1:0] pos2,
    output logic [snake_pkg::POS_W-1:0] pos3
);

    import snake_pkg::*;

    localparam logic [POS_W-1:0] LAST_POS = POS_W'(PATH_LEN - 1);

    // index 0 is the head
    logic [POS_W-1:0] body [SNAKE_LEN];
    logic [POS_W-1:0] head_next;

    // head moves forward and wraps at the end of the path
    always_comb begin
        if (body[0] == LAST_POS) begin
            head_next = '0;
        end else begin
            head_next = body[0] + 1'b1;
        end
    end

    // shift chain, each segment follows the one ahead of it
    always_ff @(posedge clock_250hz or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < SNAKE_LEN; i++) begin
                body[i] <= POS_W'(SNAKE_LEN - 1 - i);
            end
        end else if (step) begin
            body[0] <= head_next;
            for (int i = 1; i < SNAKE_LEN; i++) begin
                body[i] <= body[i-1];
            end
        end
    end

    assign pos0 = body[0];
    assign pos1 = body[1];
    assign pos2 = body[2];
    assign pos3 = body[3];

endmodule

// ==== hdl/step_timer.sv ====
`timescale 1ns/1ps

module step_timer (
    input  logic clock_250hz,
    input  logic rst_n,
    input  logic run,
    output logic step
);

    import snake_pkg::*;

    localparam logic [STEP_CNT_W-1:0] LAST_COUNT = STEP_CNT_W'(STEP_CYCLES - 1);

    logic [STEP_CNT_W-1:0] count;
    logic                  at_last;

    assign at_last = (count == LAST_COUNT);

    // one-cycle enable on the last count of a running period
    assign step = run && at_last;

    // count holds while paused so the step phase is kept
    always_ff @(posedge clock_250hz or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (run) begin
            if (at_last) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

// ==== common/snake_pkg.sv ====
package snake_pkg;

    // display geometry
    localparam int NUM_DIGITS = 8;
    localparam int DIGIT_W    = $clog2(NUM_DIGITS);
    localparam int NUM_SEGS   = 8;
    localparam int SEG_IDX_W  = $clog2(NUM_SEGS);

    // snake path and body
    localparam int PATH_LEN   = 20;
    localparam int POS_W      = 5;
    localparam int SNAKE_LEN  = 4;

    // one step every STEP_CYCLES clocks
    localparam int STEP_CYCLES = 16;
    localparam int STEP_CNT_W  = $clog2(STEP_CYCLES);

    // segment bit indices, active high
    localparam int SEG_A  = 0;
    localparam int SEG_B  = 1;
    localparam int SEG_C  = 2;
    localparam int SEG_D  = 3;
    localparam int SEG_E  = 4;
    localparam int SEG_F  = 5;
    localparam int SEG_G  = 6;
    localparam int SEG_DP = 7;

    // the middle bar and the decimal point are never part of the frame
    localparam logic [NUM_SEGS-1:0] SEG_LIT_MASK =
        ~((NUM_SEGS'(1) << SEG_G) | (NUM_SEGS'(1) << SEG_DP));

    // path entry is {digit index, segment index}
    localparam int ENTRY_W = DIGIT_W + SEG_IDX_W;

    // clockwise around the outer frame, starting top left
    localparam logic [ENTRY_W-1:0] PATH_TABLE [PATH_LEN] = '{
        {3'd0, 3'(SEG_A)}, {3'd1, 3'(SEG_A)}, {3'd2, 3'(SEG_A)}, {3'd3, 3'(SEG_A)},
        {3'd4, 3'(SEG_A)}, {3'd5, 3'(SEG_A)}, {3'd6, 3'(SEG_A)}, {3'd7, 3'(SEG_A)},
        // right edge, going down
        {3'd7, 3'(SEG_B)}, {3'd7, 3'(SEG_C)},
        // bottom row, right to left
        {3'd7, 3'(SEG_D)}, {3'd6, 3'(SEG_D)}, {3'd5, 3'(SEG_D)}, {3'd4, 3'(SEG_D)},
        {3'd3, 3'(SEG_D)}, {3'd2, 3'(SEG_D)}, {3'd1, 3'(SEG_D)}, {3'd0, 3'(SEG_D)},
        // left edge, going up
        {3'd0, 3'(SEG_E)}, {3'd0, 3'(SEG_F)}
    };

    // digit index that a path position lies on
    function automatic logic [DIGIT_W-1:0] path_digit(input logic [POS_W-1:0] pos);
        logic [ENTRY_W-1:0] entry;
        entry = '0;
        if (pos < POS_W'(PATH_LEN)) begin
            entry = PATH_TABLE[pos];
        end
        return entry[ENTRY_W-1:SEG_IDX_W];
    endfunction

    // one-hot segment mask of a path position, zero when off the path
    function automatic logic [NUM_SEGS-1:0] path_seg(input logic [POS_W-1:0] pos);
        logic [ENTRY_W-1:0]   entry;
        logic [NUM_SEGS-1:0]  mask;
        mask = '0;
        if (pos < POS_W'(PATH_LEN)) begin
            entry = PATH_TABLE[pos];
            mask  = NUM_SEGS'(1) << entry[SEG_IDX_W-1:0];
        end
        return mask;
    endfunction

endpackage
